/* game_config.svh */
`ifndef GAME_CONFIG_SVH
`define GAME_CONFIG_SVH

// Screen clamp lines and the last raster coordinates of a frame
`define GAME_SCREEN_W_LAST     799
`define GAME_SCREEN_H_LAST     599

`define GAME_FRAMES_PER_ACTION 2

// Object box sizes
`define GAME_PLAYER_W          128
`define GAME_PLAYER_H          128
`define GAME_FIREBALL_W        64
`define GAME_FIREBALL_H        64
`define GAME_ALIEN_W           128
`define GAME_ALIEN_H           128

`define GAME_STEP              1   // Pixels per move

// Top-left reset positions
`define GAME_PLAYER_X0         399
`define GAME_PLAYER_Y0         99
`define GAME_FIREBALL_X0       490
`define GAME_FIREBALL_Y0       180
`define GAME_ALIEN_X0          9
`define GAME_ALIEN_Y0          355

// Accelerometer zero offsets
`define GAME_ACCEL_X_CORR      8'd3
`define GAME_ACCEL_Y_CORR      8'd1

// Flat colours as {red, green, blue}
`define GAME_COL_PLAYER        12'h2C4
`define GAME_COL_FIREBALL      12'hF60
`define GAME_COL_ALIEN         12'h85F
`define GAME_BG_LEVEL          4'd8

`endif

/* game_pkg.sv */
package game_pkg;

  // Screen coordinate wide enough for 800x600
  typedef logic [9:0] coord_t;

  // Top-left corner of an object box
  typedef struct packed {
    coord_t h;
    coord_t v;
  } pos_t;

  // One step request per axis
  typedef struct packed {
    logic left;
    logic right;
    logic up;
    logic down;
  } move_cmd_t;

  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb_t;

  typedef enum logic [1:0] {
    REGIME_FROZEN  = 2'd2,
    REGIME_BUTTONS = 2'd3   // Objects follow buttons and accelerometer
  } regime_e;

endpackage

/* frame_tick.sv */
`timescale 1ns/1ns
`include "game_config.svh"

module frame_tick (
  input  logic        pixel_clk,
  input  logic        rst_n,
  input  logic [10:0] h_coord,
  input  logic [9:0]  v_coord,
  output logic        action_tick
);

  localparam int CNT_W = $clog2(`GAME_FRAMES_PER_ACTION + 1);

  logic             end_of_frame;
  logic [CNT_W-1:0] frames_cnt;

  // Seen the last pixel of the visible area
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      end_of_frame <= 1'b0;
    end else begin
      end_of_frame <= (h_coord[9:0] == 10'(`GAME_SCREEN_W_LAST)) &&
                      (v_coord == 10'(`GAME_SCREEN_H_LAST));
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      frames_cnt <= '0;
    end else if (frames_cnt == CNT_W'(`GAME_FRAMES_PER_ACTION)) begin
      frames_cnt <= '0;     // Wraps one clock after the last count
    end else if (end_of_frame) begin
      frames_cnt <= frames_cnt + 1'b1;
    end
  end

  assign action_tick = end_of_frame && (frames_cnt == '0);

endmodule

/* input_control.sv */
`timescale 1ns/1ns
`include "game_config.svh"

module input_control (
  input  logic                pixel_clk,
  input  logic                rst_n,
  input  logic                action_tick,
  input  logic                button_c,
  input  logic                button_u,
  input  logic                button_d,
  input  logic                button_l,
  input  logic                button_r,
  input  logic [7:0]          accel_data_x,
  input  logic [7:0]          accel_data_y,
  output logic [1:0]          demo_regime_status,
  output logic [7:0]          accel_x_end_of_frame,
  output logic [7:0]          accel_y_end_of_frame,
  output game_pkg::move_cmd_t player_cmd,
  output game_pkg::move_cmd_t fireball_cmd
);

  game_pkg::regime_e regime;
  logic [7:0]        accel_x_corr;
  logic [7:0]        accel_y_corr;

  // Flips on every clock the centre button is held
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      regime <= game_pkg::REGIME_BUTTONS;
    end else if (button_c) begin
      if (regime == game_pkg::REGIME_FROZEN) begin
        regime <= game_pkg::REGIME_BUTTONS;
      end else begin
        regime <= game_pkg::REGIME_FROZEN;
      end
    end
  end

  assign demo_regime_status = regime;

  assign accel_x_corr = accel_data_x + `GAME_ACCEL_X_CORR;  // Wraps modulo 256
  assign accel_y_corr = accel_data_y + `GAME_ACCEL_Y_CORR;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      accel_x_end_of_frame <= 8'd0;
      accel_y_end_of_frame <= 8'd0;
    end else if (action_tick) begin
      accel_x_end_of_frame <= accel_x_corr;
      accel_y_end_of_frame <= accel_y_corr;
    end
  end

  always_comb begin
    player_cmd   = '0;
    fireball_cmd = '0;
    if (regime == game_pkg::REGIME_BUTTONS) begin
      player_cmd.left    = button_l;
      player_cmd.right   = !button_l && button_r;   // Left wins
      player_cmd.up      = button_u;
      player_cmd.down    = !button_u && button_d;
      // Tilt sign steers the fireball
      fireball_cmd.left  = (accel_y_corr != 8'd0) && !accel_y_corr[7];
      fireball_cmd.right = accel_y_corr[7];
      fireball_cmd.up    = accel_x_corr[7];
      fireball_cmd.down  = (accel_x_corr != 8'd0) && !accel_x_corr[7];
    end
  end

endmodule

/* object_mover.sv */
`timescale 1ns/1ns
`include "game_config.svh"

module object_mover #(
  parameter int              OBJ_W     = 128,
  parameter int              OBJ_H     = 128,
  parameter game_pkg::pos_t  START_POS = '0
) (
  input  logic                pixel_clk,
  input  logic                rst_n,
  input  logic                action_tick,
  input  game_pkg::move_cmd_t cmd,
  output game_pkg::pos_t      pos
);

  // One clamped step along an axis with decrement first
  function automatic game_pkg::coord_t step_axis(
    input game_pkg::coord_t cur,
    input logic             dec,
    input logic             inc,
    input int               size,
    input int               last
  );
    logic [10:0]       far_edge;
    game_pkg::coord_t  nxt;
    far_edge = 11'(cur) + 11'(`GAME_STEP) + 11'(size);
    nxt      = cur;
    if (dec) begin
      if (cur < 10'(`GAME_STEP)) begin
        nxt = '0;
      end else begin
        nxt = cur - 10'(`GAME_STEP);
      end
    end else if (inc) begin
      if (far_edge >= 11'(last)) begin
        nxt = 10'(last - size);    // Box touches the clamp line
      end else begin
        nxt = cur + 10'(`GAME_STEP);
      end
    end
    return nxt;
  endfunction

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      pos <= START_POS;
    end else if (action_tick) begin
      pos.h <= step_axis(pos.h, cmd.left, cmd.right, OBJ_W, `GAME_SCREEN_W_LAST);
      pos.v <= step_axis(pos.v, cmd.up, cmd.down, OBJ_H, `GAME_SCREEN_H_LAST);
    end
  end

endmodule

/* alien_patrol.sv */
`timescale 1ns/1ns
`include "game_config.svh"

module alien_patrol #(
  parameter int ALIEN_STEP_LOG2 = 17
) (
  input  logic           pixel_clk,
  input  logic           rst_n,
  output game_pkg::pos_t alien_pos
);

  logic [ALIEN_STEP_LOG2-1:0] step_cnt;
  logic                       step_en;
  logic                       moving_left;
  game_pkg::coord_t           alien_h;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      step_cnt <= '0;
    end else begin
      step_cnt <= step_cnt + 1'b1;    // Free running
    end
  end

  assign step_en = (step_cnt == '0);

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      alien_h     <= 10'(`GAME_ALIEN_X0);
      moving_left <= 1'b1;
    end else if (step_en) begin
      if (moving_left) begin
        if (alien_h < 10'(`GAME_STEP)) begin
          alien_h     <= '0;
          moving_left <= 1'b0;        // Bounce off the left edge
        end else begin
          alien_h <= alien_h - 10'(`GAME_STEP);
        end
      end else if (11'(alien_h) + 11'(`GAME_STEP) + 11'(`GAME_ALIEN_W) >=
                   11'(`GAME_SCREEN_W_LAST)) begin
        alien_h     <= 10'(`GAME_SCREEN_W_LAST - `GAME_ALIEN_W);
        moving_left <= 1'b1;
      end else begin
        alien_h <= alien_h + 10'(`GAME_STEP);
      end
    end
  end

  assign alien_pos.h = alien_h;
  assign alien_pos.v = 10'(`GAME_ALIEN_Y0);  // Patrols on one line

endmodule

/* pixel_renderer.sv */
`timescale 1ns/1ns
`include "game_config.svh"

module pixel_renderer (
  input  logic [10:0]    h_coord,
  input  logic [9:0]     v_coord,
  input  logic [2:0]     sw,
  input  game_pkg::pos_t player_pos,
  input  game_pkg::pos_t fireball_pos,
  input  game_pkg::pos_t alien_pos,
  output game_pkg::rgb_t pixel
);

  logic fireball_hit;
  logic player_hit;
  logic alien_hit;

  // Inclusive box test with the far edge at corner plus size
  function automatic logic box_hit(
    input game_pkg::coord_t px,
    input game_pkg::coord_t py,
    input game_pkg::pos_t   corner,
    input int               w,
    input int               h
  );
    logic in_h;
    logic in_v;
    in_h = (px >= corner.h) && (11'(px) <= 11'(corner.h) + 11'(w));
    in_v = (py >= corner.v) && (11'(py) <= 11'(corner.v) + 11'(h));
    return in_h && in_v;
  endfunction

  assign fireball_hit = box_hit(h_coord[9:0], v_coord, fireball_pos,
                                `GAME_FIREBALL_W, `GAME_FIREBALL_H);
  assign player_hit   = box_hit(h_coord[9:0], v_coord, player_pos,
                                `GAME_PLAYER_W, `GAME_PLAYER_H);
  assign alien_hit    = box_hit(h_coord[9:0], v_coord, alien_pos,
                                `GAME_ALIEN_W, `GAME_ALIEN_H);

  // Fireball drawn on top and alien at the back
  always_comb begin
    if (fireball_hit) begin
      pixel = game_pkg::rgb_t'(`GAME_COL_FIREBALL);
    end else if (player_hit) begin
      pixel = game_pkg::rgb_t'(`GAME_COL_PLAYER);
    end else if (alien_hit) begin
      pixel = game_pkg::rgb_t'(`GAME_COL_ALIEN);
    end else begin
      pixel.red   = sw[0] ? `GAME_BG_LEVEL : 4'd0;
      pixel.green = sw[1] ? `GAME_BG_LEVEL : 4'd0;
      pixel.blue  = sw[2] ? `GAME_BG_LEVEL : 4'd0;
    end
  end

endmodule

/* game_top.sv */
`timescale 1ns/1ns
`include "game_config.svh"

module game_top #(
  parameter int ALIEN_STEP_LOG2 = 17
) (
  input  logic        pixel_clk,
  input  logic        rst_n,
  input  logic        button_c,
  input  logic        button_u,
  input  logic        button_d,
  input  logic        button_r,
  input  logic        button_l,
  input  logic [7:0]  accel_data_x,
  input  logic [7:0]  accel_data_y,
  output logic [7:0]  accel_x_end_of_frame,
  output logic [7:0]  accel_y_end_of_frame,
  input  logic [10:0] h_coord,
  input  logic [9:0]  v_coord,
  output logic [3:0]  red,
  output logic [3:0]  green,
  output logic [3:0]  blue,
  input  logic [2:0]  sw,
  output logic [1:0]  demo_regime_status
);

  localparam game_pkg::pos_t PLAYER_START =
    '{h: 10'(`GAME_PLAYER_X0), v: 10'(`GAME_PLAYER_Y0)};
  localparam game_pkg::pos_t FIREBALL_START =
    '{h: 10'(`GAME_FIREBALL_X0), v: 10'(`GAME_FIREBALL_Y0)};

  logic                action_tick;   // One clock per game step
  game_pkg::move_cmd_t player_cmd;
  game_pkg::move_cmd_t fireball_cmd;
  game_pkg::pos_t      player_pos;
  game_pkg::pos_t      fireball_pos;
  game_pkg::pos_t      alien_pos;
  game_pkg::rgb_t      pixel;

  frame_tick u_frame_tick (
    .pixel_clk   (pixel_clk),
    .rst_n       (rst_n),
    .h_coord     (h_coord),
    .v_coord     (v_coord),
    .action_tick (action_tick)
  );

  input_control u_input_control (
    .pixel_clk            (pixel_clk),
    .rst_n                (rst_n),
    .action_tick          (action_tick),
    .button_c             (button_c),
    .button_u             (button_u),
    .button_d             (button_d),
    .button_l             (button_l),
    .button_r             (button_r),
    .accel_data_x         (accel_data_x),
    .accel_data_y         (accel_data_y),
    .demo_regime_status   (demo_regime_status),
    .accel_x_end_of_frame (accel_x_end_of_frame),
    .accel_y_end_of_frame (accel_y_end_of_frame),
    .player_cmd           (player_cmd),
    .fireball_cmd         (fireball_cmd)
  );

  object_mover #(
    .OBJ_W     (`GAME_PLAYER_W),
    .OBJ_H     (`GAME_PLAYER_H),
    .START_POS (PLAYER_START)
  ) u_player_mover (
    .pixel_clk   (pixel_clk),
    .rst_n       (rst_n),
    .action_tick (action_tick),
    .cmd         (player_cmd),
    .pos         (player_pos)
  );

  object_mover #(
    .OBJ_W     (`GAME_FIREBALL_W),
    .OBJ_H     (`GAME_FIREBALL_H),
    .START_POS (FIREBALL_START)
  ) u_fireball_mover (
    .pixel_clk   (pixel_clk),
    .rst_n       (rst_n),
    .action_tick (action_tick),
    .cmd         (fireball_cmd),
    .pos         (fireball_pos)
  );

  alien_patrol #(
    .ALIEN_STEP_LOG2 (ALIEN_STEP_LOG2)
  ) u_alien_patrol (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .alien_pos (alien_pos)
  );

  pixel_renderer u_pixel_renderer (
    .h_coord      (h_coord),
    .v_coord      (v_coord),
    .sw           (sw),
    .player_pos   (player_pos),
    .fireball_pos (fireball_pos),
    .alien_pos    (alien_pos),
    .pixel        (pixel)
  );

  assign red   = pixel.red;
  assign green = pixel.green;
  assign blue  = pixel.blue;

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int RESET_CYCLES = 5
) (
  output logic pixel_clk,
  output logic rst_n
);

  initial begin
    pixel_clk = 1'b0;
    forever #2 pixel_clk = ~pixel_clk;   // 4 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge pixel_clk);
    rst_n <= 1'b1;
  end

endmodule

/* game_chk.sv */
`timescale 1ns/1ns
`include "game_config.svh"

module game_chk (
  input logic           pixel_clk,
  input logic           rst_n,
  input logic           action_tick,
  input logic [1:0]     regime,
  input game_pkg::pos_t player_pos,
  input game_pkg::pos_t fireball_pos,
  input game_pkg::pos_t alien_pos
);

  int   assert_fails = 0;   // Summed into the testbench error count
  logic in_bounds;

  // Far edges of all boxes stay on or inside the clamp lines
  assign in_bounds =
    (int'(player_pos.h) + `GAME_PLAYER_W <= `GAME_SCREEN_W_LAST) &&
    (int'(player_pos.v) + `GAME_PLAYER_H <= `GAME_SCREEN_H_LAST) &&
    (int'(fireball_pos.h) + `GAME_FIREBALL_W <= `GAME_SCREEN_W_LAST) &&
    (int'(fireball_pos.v) + `GAME_FIREBALL_H <= `GAME_SCREEN_H_LAST) &&
    (int'(alien_pos.h) + `GAME_ALIEN_W <= `GAME_SCREEN_W_LAST);

  a_tick_one_clock: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    action_tick |=> !action_tick)
    else begin
      $error("action_tick stayed high for more than one clock");
      assert_fails++;
    end

  a_regime_legal: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    (regime == 2'd3) || (regime == 2'd2))
    else begin
      $error("regime left the values 3 and 2");
      assert_fails++;
    end

  a_pos_clamped: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    in_bounds)
    else begin
      $error("an object position is beyond its clamp line");
      assert_fails++;
    end

endmodule

/* game_tb.sv */
`timescale 1ns/1ns
`include "game_config.svh"

module game_tb;

  localparam int ALIEN_LOG2 = 6;

  logic                pixel_clk;
  logic                rst_n;
  logic                button_c;
  game_pkg::move_cmd_t buttons;   // Direction buttons l, r, u, d
  logic [7:0]          accel_data_x;
  logic [7:0]          accel_data_y;
  logic [10:0]         h_coord;
  logic [9:0]          v_coord;
  logic [2:0]          sw;
  logic [7:0]          accel_x_end_of_frame;
  logic [7:0]          accel_y_end_of_frame;
  logic [3:0]          red;
  logic [3:0]          green;
  logic [3:0]          blue;
  logic [1:0]          demo_regime_status;

  logic [31:0] rng_state = 32'h3d3c;

  // Reference model state as the DUT holds it after each rising edge
  bit          m_eof;
  int          m_fcnt;
  logic [1:0]  m_regime;
  logic [7:0]  m_cap_x;
  logic [7:0]  m_cap_y;
  int          m_ph;
  int          m_pv;
  int          m_fh;
  int          m_fv;
  int          m_ah;
  bit          m_al;      // Alien moving left
  int          m_scnt;
  int          n_ticks = 0;
  int          n_bounces = 0;
  int          n_checks = 0;
  int          n_errors = 0;
  bit          checking = 1'b0;

  tb_clock_gen u_clock_gen (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n)
  );

  game_top #(
    .ALIEN_STEP_LOG2 (ALIEN_LOG2)
  ) u_dut (
    .pixel_clk            (pixel_clk),
    .rst_n                (rst_n),
    .button_c             (button_c),
    .button_u             (buttons.up),
    .button_d             (buttons.down),
    .button_r             (buttons.right),
    .button_l             (buttons.left),
    .accel_data_x         (accel_data_x),
    .accel_data_y         (accel_data_y),
    .accel_x_end_of_frame (accel_x_end_of_frame),
    .accel_y_end_of_frame (accel_y_end_of_frame),
    .h_coord              (h_coord),
    .v_coord              (v_coord),
    .red                  (red),
    .green                (green),
    .blue                 (blue),
    .sw                   (sw),
    .demo_regime_status   (demo_regime_status)
  );

  bind game_top game_chk u_chk (
    .pixel_clk    (pixel_clk),
    .rst_n        (rst_n),
    .action_tick  (action_tick),
    .regime       (demo_regime_status),
    .player_pos   (player_pos),
    .fireball_pos (fireball_pos),
    .alien_pos    (alien_pos)
  );

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // One clamped step on one axis where decrement wins
  function automatic int move_axis(input int cur, input bit dec, input bit inc,
                                   input int size, input int last);
    if (dec) begin
      return (cur < `GAME_STEP) ? 0 : cur - `GAME_STEP;
    end
    if (inc) begin
      return (cur + `GAME_STEP + size >= last) ? last - size : cur + `GAME_STEP;
    end
    return cur;
  endfunction

  function automatic bit in_box(input int x, input int y, input int bx, input int by,
                                input int w, input int h);
    return (x >= bx) && (x <= bx + w) && (y >= by) && (y <= by + h);
  endfunction

  function automatic logic [11:0] expected_pixel(input int x, input int y,
                                                 input logic [2:0] s);
    if (in_box(x, y, m_fh, m_fv, `GAME_FIREBALL_W, `GAME_FIREBALL_H)) begin
      return `GAME_COL_FIREBALL;
    end
    if (in_box(x, y, m_ph, m_pv, `GAME_PLAYER_W, `GAME_PLAYER_H)) begin
      return `GAME_COL_PLAYER;
    end
    if (in_box(x, y, m_ah, `GAME_ALIEN_Y0, `GAME_ALIEN_W, `GAME_ALIEN_H)) begin
      return `GAME_COL_ALIEN;
    end
    return {s[0] ? `GAME_BG_LEVEL : 4'd0, s[1] ? `GAME_BG_LEVEL : 4'd0,
            s[2] ? `GAME_BG_LEVEL : 4'd0};
  endfunction

  // Uses the inputs the DUT sampled at this edge
  task automatic model_step();
    logic [7:0]          cx;
    logic [7:0]          cy;
    game_pkg::move_cmd_t pc;
    game_pkg::move_cmd_t fc;
    bit                  act;
    bit                  step_en;
    cx      = accel_data_x + `GAME_ACCEL_X_CORR;
    cy      = accel_data_y + `GAME_ACCEL_Y_CORR;
    act     = m_eof && (m_fcnt == 0);
    step_en = (m_scnt == 0);
    pc      = '0;
    fc      = '0;
    if (m_regime == 2'd3) begin
      pc.left  = buttons.left;
      pc.right = !buttons.left && buttons.right;
      pc.up    = buttons.up;
      pc.down  = !buttons.up && buttons.down;
      fc.left  = (cy != 8'd0) && !cy[7];
      fc.right = cy[7];
      fc.up    = cx[7];
      fc.down  = (cx != 8'd0) && !cx[7];
    end
    if (!rst_n) begin
      m_eof    = 1'b0;
      m_fcnt   = 0;
      m_regime = 2'd3;
      m_cap_x  = 8'd0;
      m_cap_y  = 8'd0;
      m_ph     = `GAME_PLAYER_X0;
      m_pv     = `GAME_PLAYER_Y0;
      m_fh     = `GAME_FIREBALL_X0;
      m_fv     = `GAME_FIREBALL_Y0;
      m_ah     = `GAME_ALIEN_X0;
      m_al     = 1'b1;
      m_scnt   = 0;
    end else begin
      if (m_fcnt == `GAME_FRAMES_PER_ACTION) begin
        m_fcnt = 0;
      end else if (m_eof) begin
        m_fcnt++;
      end
      m_eof = (h_coord[9:0] == 10'(`GAME_SCREEN_W_LAST)) &&
              (v_coord == 10'(`GAME_SCREEN_H_LAST));
      if (button_c) begin
        m_regime = (m_regime == 2'd3) ? 2'd2 : 2'd3;
      end
      if (act) begin
        n_ticks++;
        m_cap_x = cx;
        m_cap_y = cy;
        m_ph = move_axis(m_ph, pc.left, pc.right, `GAME_PLAYER_W, `GAME_SCREEN_W_LAST);
        m_pv = move_axis(m_pv, pc.up, pc.down, `GAME_PLAYER_H, `GAME_SCREEN_H_LAST);
        m_fh = move_axis(m_fh, fc.left, fc.right, `GAME_FIREBALL_W, `GAME_SCREEN_W_LAST);
        m_fv = move_axis(m_fv, fc.up, fc.down, `GAME_FIREBALL_H, `GAME_SCREEN_H_LAST);
      end
      m_scnt = (m_scnt + 1) % (1 << ALIEN_LOG2);
      if (step_en && m_al) begin
        if (m_ah < `GAME_STEP) begin
          m_ah = 0;
          m_al = 1'b0;
          n_bounces++;
        end else begin
          m_ah = m_ah - `GAME_STEP;
        end
      end else if (step_en) begin
        if (m_ah + `GAME_STEP + `GAME_ALIEN_W >= `GAME_SCREEN_W_LAST) begin
          m_ah = `GAME_SCREEN_W_LAST - `GAME_ALIEN_W;
          m_al = 1'b1;
          n_bounces++;
        end else begin
          m_ah = m_ah + `GAME_STEP;
        end
      end
    end
  endtask

  // Focus 0 player, 1 fireball, 2 alien, else anywhere on screen
  task automatic pick_probe(input int focus, output int ph, output int pv);
    int sel;
    int bh;
    int bv;
    int bw;
    int bhh;
    sel = (focus >= 0) ? focus : int'(next_rand() % 4);
    case (sel)
      0: begin
        bh  = m_ph;
        bv  = m_pv;
        bw  = `GAME_PLAYER_W;
        bhh = `GAME_PLAYER_H;
      end
      1: begin
        bh  = m_fh;
        bv  = m_fv;
        bw  = `GAME_FIREBALL_W;
        bhh = `GAME_FIREBALL_H;
      end
      2: begin
        bh  = m_ah;
        bv  = `GAME_ALIEN_Y0;
        bw  = `GAME_ALIEN_W;
        bhh = `GAME_ALIEN_H;
      end
      default: begin
        bh  = 0;
        bv  = 0;
        bw  = `GAME_SCREEN_W_LAST;
        bhh = `GAME_SCREEN_H_LAST;
      end
    endcase
    ph = bh + int'(next_rand() % (bw + 4)) - 2;   // Just past both edges
    pv = bv + int'(next_rand() % (bhh + 4)) - 2;
    ph = (ph < 0) ? 0 : (ph > `GAME_SCREEN_W_LAST) ? `GAME_SCREEN_W_LAST : ph;
    pv = (pv < 0) ? 0 : (pv > `GAME_SCREEN_H_LAST) ? `GAME_SCREEN_H_LAST : pv;
  endtask

  task automatic drive_cycle(input bit frame_end, input int focus);
    int ph;
    int pv;
    @(posedge pixel_clk);
    model_step();
    pick_probe(focus, ph, pv);
    if (frame_end) begin
      ph = `GAME_SCREEN_W_LAST;
      pv = `GAME_SCREEN_H_LAST;
    end
    h_coord <= 11'(ph);
    v_coord <= 10'(pv);
    sw      <= 3'(next_rand());
  endtask

  function automatic game_pkg::move_cmd_t chase_fireball();
    game_pkg::move_cmd_t b;
    b.left  = m_ph > m_fh;
    b.right = m_ph < m_fh;
    b.up    = m_pv > m_fv;
    b.down  = m_pv < m_fv;
    return b;
  endfunction

  task automatic report_timeout(input string what);
    $display("Timeout: %s did not happen within its cycle limit", what);
    $display("Checks: %0d, errors: %0d", n_checks, n_errors + 1);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  // Mode 0 accel only, 1 random buttons, 2 held push, 3 player chases fireball
  task automatic run_ticks(input int n, input int mode, input game_pkg::move_cmd_t push);
    int target;
    int frames;
    int focus;
    target = n_ticks + n;
    frames = 0;
    focus  = (mode == 3) ? 1 : -1;
    while (n_ticks < target) begin
      if (frames > 3 * n + 10) begin
        report_timeout("action tick");
      end
      drive_cycle(1'b1, focus);
      case (mode)
        0: buttons <= '0;
        1: begin
          if (next_rand() % 8 == 0) begin
            buttons <= game_pkg::move_cmd_t'(4'(next_rand()));
          end
        end
        2: buttons <= push;
        default: buttons <= chase_fireball();
      endcase
      if (mode != 3 || next_rand() % 16 == 0) begin
        accel_data_x <= 8'(next_rand());
        accel_data_y <= 8'(next_rand());
      end
      repeat (3) begin
        drive_cycle(1'b0, focus);
        if (mode == 0) begin
          accel_data_x <= 8'(next_rand());   // Changes between ticks too
          accel_data_y <= 8'(next_rand());
        end
      end
      frames++;
    end
  endtask

  task automatic toggle_regime();
    drive_cycle(1'b0, -1);
    button_c <= 1'b1;
    drive_cycle(1'b0, -1);
    button_c <= 1'b0;
    drive_cycle(1'b0, -1);
  endtask

  task automatic end_test(input string name, input int err0);
    $display("Test %s finished with %0d errors", name, n_errors - err0);
  endtask

  always @(negedge pixel_clk) begin
    if (checking) begin
      compare("demo_regime_status", 32'(demo_regime_status), 32'(m_regime));
      compare("accel_x_end_of_frame", 32'(accel_x_end_of_frame), 32'(m_cap_x));
      compare("accel_y_end_of_frame", 32'(accel_y_end_of_frame), 32'(m_cap_y));
      compare("pixel", 32'({red, green, blue}),
              32'(expected_pixel(int'(h_coord[9:0]), int'(v_coord), sw)));
    end
  end

  initial begin
    int err0;
    int waited;
    int target;
    int len;
    button_c     = 1'b0;
    buttons      = '0;
    accel_data_x = 8'd0;
    accel_data_y = 8'd0;
    h_coord      = 11'd0;
    v_coord      = 10'd0;
    sw           = 3'd0;
    waited = 0;
    while (rst_n !== 1'b1) begin
      if (waited > 20) begin
        report_timeout("reset release");
      end
      drive_cycle(1'b0, -1);
      waited++;
    end
    checking = 1'b1;

    err0 = n_errors;
    @(negedge pixel_clk);
    compare("demo_regime_status", 32'(demo_regime_status), 32'(game_pkg::REGIME_BUTTONS));
    compare("accel_x_end_of_frame", 32'(accel_x_end_of_frame), 32'd0);
    compare("accel_y_end_of_frame", 32'(accel_y_end_of_frame), 32'd0);
    repeat (40) drive_cycle(1'b0, -1);
    end_test("reset values", err0);

    err0 = n_errors;
    repeat (30) begin
      len = 1 + int'(next_rand() % 5);
      drive_cycle(1'b0, -1);
      button_c <= 1'b1;
      repeat (len) drive_cycle(1'b0, -1);
      button_c <= 1'b0;
      repeat (1 + int'(next_rand() % 4)) drive_cycle(1'b0, -1);
    end
    if (m_regime != 2'd3) begin
      toggle_regime();
    end
    end_test("regime toggle", err0);

    err0 = n_errors;
    run_ticks(12, 0, '0);
    end_test("accelerometer capture", err0);

    err0 = n_errors;
    run_ticks(150, 1, '0);
    run_ticks(420, 2, '{left: 1'b1, right: 1'b0, up: 1'b0, down: 1'b0});
    run_ticks(120, 2, '{left: 1'b0, right: 1'b0, up: 1'b1, down: 1'b0});
    toggle_regime();                      // Objects hold still while frozen
    run_ticks(20, 1, '0);
    toggle_regime();
    run_ticks(700, 2, '{left: 1'b0, right: 1'b1, up: 1'b0, down: 1'b0});
    run_ticks(500, 2, '{left: 1'b0, right: 1'b0, up: 1'b0, down: 1'b1});
    end_test("player moves", err0);

    err0 = n_errors;
    run_ticks(300, 3, '0);
    end_test("fireball moves", err0);

    err0 = n_errors;
    buttons <= '0;
    target = n_bounces + 2;               // One bounce at each edge
    waited = 0;
    while (n_bounces < target) begin
      if (waited > 64 * 1800) begin
        report_timeout("alien bounce");
      end
      drive_cycle(1'b0, 2);
      waited++;
    end
    end_test("alien patrol", err0);

    checking = 1'b0;
    n_errors = n_errors + u_dut.u_chk.assert_fails;
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* game_top.f */
+incdir+.
game_pkg.sv
frame_tick.sv
input_control.sv
object_mover.sv
alien_patrol.sv
pixel_renderer.sv
game_top.sv
tb_clock_gen.sv
game_chk.sv
game_tb.sv

/* Bender.yml */
package:
  name: game_top

export_include_dirs:
  - .

sources:
  - game_pkg.sv
  - frame_tick.sv
  - input_control.sv
  - object_mover.sv
  - alien_patrol.sv
  - pixel_renderer.sv
  - game_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - game_chk.sv
      - game_tb.sv
